// File: rtl/flit_buffer_params.svh
`ifndef FLIT_BUFFER_PARAMS_SVH
`define FLIT_BUFFER_PARAMS_SVH

// number of virtual channels sharing one flit memory
`define FB_NUM_VC 2

// flits per VC, must be a power of two so the pointers wrap by themselves
`define FB_VC_DEPTH 4

// payload bits carried by each flit
`define FB_PAYLOAD_W 32

// binary VC index, at least one bit
`define FB_VC_IDX_W ((`FB_NUM_VC > 1) ? $clog2(`FB_NUM_VC) : 1)

// per-VC pointer, at least one bit
`define FB_PTR_W ((`FB_VC_DEPTH > 1) ? $clog2(`FB_VC_DEPTH) : 1)

// occupancy count, one extra bit to tell full from empty
`define FB_DEPTH_W (`FB_PTR_W + 1)

`endif

// File: rtl/flit_buffer_pkg.sv
package flit_buffer_pkg;

`include "flit_buffer_params.svh"

    // flit kind, msb marks a head and lsb marks a tail
    typedef enum logic [1:0] {
        FLIT_BODY   = 2'b00,
        FLIT_TAIL   = 2'b01,
        FLIT_HEAD   = 2'b10,
        FLIT_SINGLE = 2'b11
    } flit_kind_e;

    // stored and returned flit, kind on top of the payload
    typedef struct packed {
        flit_kind_e                kind;
        logic [`FB_PAYLOAD_W-1:0] payload;
    } flit_t;

    // one bit per VC
    typedef logic [`FB_NUM_VC-1:0] vc_onehot_t;

    // binary VC number
    typedef logic [`FB_VC_IDX_W-1:0] vc_idx_t;

    // slot inside one VC region
    typedef logic [`FB_PTR_W-1:0] buf_ptr_t;

    // one pointer per VC, VC 0 in the low slice
    typedef buf_ptr_t [`FB_NUM_VC-1:0] vc_ptr_vec_t;

    // shared memory address, VC region picks the upper bits
    typedef struct packed {
        vc_idx_t  vc;
        buf_ptr_t ptr;
    } ram_addr_t;

endpackage

// File: rtl/vc_ptr_ctrl.sv
`timescale 1ns/1ps
`include "flit_buffer_params.svh"

module vc_ptr_ctrl import flit_buffer_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        wr_en,
    input  vc_onehot_t  vc_num_wr,
    input  logic        rd_en,
    input  vc_onehot_t  vc_num_rd,
    input  vc_onehot_t  ssa_rd,
    output vc_ptr_vec_t wr_ptrs,
    output vc_ptr_vec_t rd_ptrs,
    output vc_onehot_t  rd_vc,
    output logic        wr_fire,
    output logic        rd_fire,
    output vc_onehot_t  vc_not_empty
);

    // count value of a full VC
    localparam logic [`FB_DEPTH_W-1:0] depth_full = `FB_DEPTH_W'(`FB_VC_DEPTH);

    // flits held per VC
    logic [`FB_NUM_VC-1:0][`FB_DEPTH_W-1:0] depth;

    // requested and accepted operations, one bit per VC
    vc_onehot_t wr_req;
    vc_onehot_t wr_ok;
    vc_onehot_t rd_ok;

    // normal read wins, speculative SA read only when rd_en is low
    assign rd_vc  = rd_en ? vc_num_rd : ssa_rd;
    assign wr_req = wr_en ? vc_num_wr : '0;

    always_comb begin
        for (int i = 0; i < `FB_NUM_VC; i++) begin
            vc_not_empty[i] = (depth[i] != '0);
            // full VC refuses the write, even with a read in the same cycle
            wr_ok[i] = wr_req[i] && (depth[i] != depth_full);
            // empty VC ignores the read
            rd_ok[i] = rd_vc[i] && vc_not_empty[i];
        end
    end

    // at most one VC per strobe since selects are one-hot
    assign wr_fire = |wr_ok;
    assign rd_fire = |rd_ok;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptrs <= '0;
            rd_ptrs <= '0;
            depth   <= '0;
        end else begin
            for (int i = 0; i < `FB_NUM_VC; i++) begin
                // pointers wrap inside the VC region
                if (wr_ok[i]) begin
                    wr_ptrs[i] <= wr_ptrs[i] + 1'b1;
                end
                if (rd_ok[i]) begin
                    rd_ptrs[i] <= rd_ptrs[i] + 1'b1;
                end
                // write and read together leave the count alone
                if (wr_ok[i] && !rd_ok[i]) begin
                    depth[i] <= depth[i] + 1'b1;
                end else if (!wr_ok[i] && rd_ok[i]) begin
                    depth[i] <= depth[i] - 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/vc_addr_gen.sv
`timescale 1ns/1ps
`include "flit_buffer_params.svh"

module vc_addr_gen import flit_buffer_pkg::*; (
    input  vc_onehot_t  vc_num_wr,
    input  vc_onehot_t  rd_vc,
    input  vc_ptr_vec_t wr_ptrs,
    input  vc_ptr_vec_t rd_ptrs,
    output ram_addr_t   wr_addr,
    output ram_addr_t   rd_addr
);

    // one-hot select to shared memory address
    // each VC contributes its number and pointer only when its bit is set,
    // so an all-zero select yields address zero
    function automatic ram_addr_t onehot_addr(
        input vc_onehot_t  sel,
        input vc_ptr_vec_t ptrs
    );
        ram_addr_t addr;
        addr = '0;
        for (int i = 0; i < `FB_NUM_VC; i++) begin
            // masked OR gives the binary VC index
            addr.vc  = addr.vc | (vc_idx_t'(i) & {`FB_VC_IDX_W{sel[i]}});
            // same mask picks that VC's pointer
            addr.ptr = addr.ptr | (ptrs[i] & {`FB_PTR_W{sel[i]}});
        end
        return addr;
    endfunction

    // write side follows the raw write select
    // the memory only stores on wr_fire
    assign wr_addr = onehot_addr(vc_num_wr, wr_ptrs);

    // read side follows the chosen read source
    assign rd_addr = onehot_addr(rd_vc, rd_ptrs);

endmodule

// File: rtl/flit_ram.sv
`timescale 1ns/1ps
`include "flit_buffer_params.svh"

module flit_ram import flit_buffer_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      wr_fire,
    input  ram_addr_t wr_addr,
    input  flit_t     din,
    input  logic      rd_fire,
    input  ram_addr_t rd_addr,
    output flit_t     dout
);

    // one region of FB_VC_DEPTH slots per VC
    flit_t mem [`FB_NUM_VC * `FB_VC_DEPTH];

    // store accepted writes only
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_addr] <= din;
        end
    end

    // read register, holds its value on refused or missing reads
    // write and read of one slot never meet, a VC with room
    // and data has distinct read and write pointers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dout <= '0;
        end else if (rd_fire) begin
            dout <= mem[rd_addr];
        end
    end

endmodule

// File: rtl/flit_buffer.sv
`timescale 1ns/1ps

module flit_buffer import flit_buffer_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  flit_t      din,
    input  logic       wr_en,
    input  vc_onehot_t vc_num_wr,
    input  logic       rd_en,
    input  vc_onehot_t vc_num_rd,
    input  vc_onehot_t ssa_rd,
    output flit_t      dout,
    output vc_onehot_t vc_not_empty
);

    // per-VC pointers
    vc_ptr_vec_t wr_ptrs;
    vc_ptr_vec_t rd_ptrs;

    // chosen read VC, one-hot
    vc_onehot_t rd_vc;

    // accepted operations
    logic wr_fire;
    logic rd_fire;

    // shared memory addresses
    ram_addr_t wr_addr;
    ram_addr_t rd_addr;

    // pointers, counts and acceptance
    vc_ptr_ctrl u_ptr_ctrl (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .vc_num_wr    (vc_num_wr),
        .rd_en        (rd_en),
        .vc_num_rd    (vc_num_rd),
        .ssa_rd       (ssa_rd),
        .wr_ptrs      (wr_ptrs),
        .rd_ptrs      (rd_ptrs),
        .rd_vc        (rd_vc),
        .wr_fire      (wr_fire),
        .rd_fire      (rd_fire),
        .vc_not_empty (vc_not_empty)
    );

    // select to address conversion
    vc_addr_gen u_addr_gen (
        .vc_num_wr (vc_num_wr),
        .rd_vc     (rd_vc),
        .wr_ptrs   (wr_ptrs),
        .rd_ptrs   (rd_ptrs),
        .wr_addr   (wr_addr),
        .rd_addr   (rd_addr)
    );

    // shared storage with registered output
    flit_ram u_ram (
        .clk     (clk),
        .reset   (reset),
        .wr_fire (wr_fire),
        .wr_addr (wr_addr),
        .din     (din),
        .rd_fire (rd_fire),
        .rd_addr (rd_addr),
        .dout    (dout)
    );

endmodule

// File: dv/flit_buffer_tb.sv
`timescale 1ns/1ps
`include "flit_buffer_params.svh"

module flit_buffer_tb import flit_buffer_pkg::*; ();

    // cycles a single wait may take
    localparam int wait_limit = 20;

    logic       clk = 1'b0;
    logic       reset;
    flit_t      din;
    logic       wr_en;
    vc_onehot_t vc_num_wr;
    logic       rd_en;
    vc_onehot_t vc_num_rd;
    vc_onehot_t ssa_rd;
    flit_t      dout;
    vc_onehot_t vc_not_empty;

    // reference model state with one queue per VC
    flit_t      vc_q [`FB_NUM_VC][$];
    flit_t      exp_dout;
    vc_onehot_t exp_ne;

    int         errors;
    int         checks;
    int         test_start_errors;
    logic [15:0] lfsr_state;

    flit_buffer uut (
        .clk          (clk),
        .reset        (reset),
        .din          (din),
        .wr_en        (wr_en),
        .vc_num_wr    (vc_num_wr),
        .rd_en        (rd_en),
        .vc_num_rd    (vc_num_rd),
        .ssa_rd       (ssa_rd),
        .dout         (dout),
        .vc_not_empty (vc_not_empty)
    );

    // 40 ns period
    always #20 clk = ~clk;

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // 16-bit galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    function automatic vc_onehot_t onehot(input int i);
        return vc_onehot_t'(1) << i;
    endfunction

    // -1 when no bit is set
    function automatic int first_set(input vc_onehot_t sel);
        for (int i = 0; i < `FB_NUM_VC; i++) begin
            if (sel[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // directed flit whose kind cycles with n
    function automatic flit_t make_flit(input int n);
        flit_t f;
        f.kind    = flit_kind_e'(n[1:0]);
        f.payload = `FB_PAYLOAD_W'(32'hC0DE_0000 + n);
        return f;
    endfunction

    // one clock edge of the buffer rules
    function automatic void model_step(input flit_t d, input logic wr, input vc_onehot_t wvc,
                                       input logic rd, input vc_onehot_t rvc,
                                       input vc_onehot_t ssa);
        int wi;
        int ri;
        logic take_wr;
        logic take_rd;
        wi = wr ? first_set(wvc) : -1;
        // normal read strobe beats the speculative one
        ri = rd ? first_set(rvc) : first_set(ssa);
        // both decisions on the state before the edge
        take_wr = (wi >= 0) && (vc_q[wi].size() < `FB_VC_DEPTH);
        take_rd = (ri >= 0) && (vc_q[ri].size() > 0);
        if (take_rd) begin
            exp_dout = vc_q[ri].pop_front();
        end
        if (take_wr) begin
            vc_q[wi].push_back(d);
        end
        for (int i = 0; i < `FB_NUM_VC; i++) begin
            exp_ne[i] = (vc_q[i].size() != 0);
        end
    endfunction

    // model follows the inputs held over each rising edge
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `FB_NUM_VC; i++) begin
                vc_q[i].delete();
            end
            exp_dout = '0;
            exp_ne   = '0;
        end else begin
            model_step(din, wr_en, vc_num_wr, rd_en, vc_num_rd, ssa_rd);
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        check_value(64'(dout), 64'(exp_dout), "dout vs model");
        check_value(64'(vc_not_empty), 64'(exp_ne), "vc_not_empty vs model");
    end

    task automatic idle_inputs();
        din       = '0;
        wr_en     = 1'b0;
        vc_num_wr = '0;
        rd_en     = 1'b0;
        vc_num_rd = '0;
        ssa_rd    = '0;
    endtask

    // new inputs on the falling edge stay put over the next rising edge
    task automatic drive(input logic wr, input int wvc, input flit_t d,
                         input logic rd, input int rvc, input vc_onehot_t ssa);
        @(negedge clk);
        wr_en     = wr;
        vc_num_wr = onehot(wvc);
        din       = d;
        rd_en     = rd;
        vc_num_rd = onehot(rvc);
        ssa_rd    = ssa;
    endtask

    task automatic write_flit(input int vc, input flit_t f);
        drive(1'b1, vc, f, 1'b0, 0, '0);
    endtask

    task automatic read_vc(input int vc);
        drive(1'b0, 0, '0, 1'b1, vc, '0);
    endtask

    task automatic ssa_read(input int vc);
        drive(1'b0, 0, '0, 1'b0, 0, onehot(vc));
    endtask

    // read result shows one cycle after the read is issued
    task automatic expect_read(input flit_t f, input string what);
        @(negedge clk);
        idle_inputs();
        check_value(64'(dout), 64'(f), what);
    endtask

    task automatic wait_not_empty(input int vc);
        int n;
        n = 0;
        @(negedge clk);
        idle_inputs();
        while (vc_not_empty[vc] !== 1'b1) begin
            if (n == wait_limit) begin
                errors++;
                $display("timeout while waiting for VC %0d to hold a flit", vc);
                return;
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-16s done, %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // stops a run that never reaches its end
    initial begin : watchdog
        repeat (4000) @(posedge clk);
        $display("simulation stopped, run exceeded its cycle limit");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        flit_t       prev;
        flit_t       r_flit;
        logic [31:0] bits;
        logic [1:0]  mode;
        logic        r_wr;
        int          r_wvc;
        int          r_rvc;
        int          r_svc;
        errors            = 0;
        checks            = 0;
        test_start_errors = 0;
        lfsr_state        = 16'd56;
        exp_dout          = '0;
        exp_ne            = '0;
        reset             = 1'b1;
        idle_inputs();
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // reset values
        check_value(64'(vc_not_empty), 64'(0), "vc_not_empty after reset");
        check_value(64'(dout), 64'(0), "dout after reset");
        end_test("reset");

        // interleaved writes come back in per-VC order
        for (int k = 0; k < 6; k++) begin
            write_flit(k % `FB_NUM_VC, make_flit(k));
        end
        for (int v = 0; v < `FB_NUM_VC; v++) begin
            wait_not_empty(v);
        end
        for (int k = 0; k < 6; k++) begin
            read_vc(k % `FB_NUM_VC);
            expect_read(make_flit(k), "vc order read");
        end
        end_test("vc order");

        // overfill VC 1 so the extra two are lost
        for (int k = 0; k < `FB_VC_DEPTH + 2; k++) begin
            write_flit(1, make_flit(100 + k));
        end
        wait_not_empty(1);
        for (int k = 0; k < `FB_VC_DEPTH; k++) begin
            read_vc(1);
            expect_read(make_flit(100 + k), "full vc read");
        end
        check_value(64'(vc_not_empty), 64'(0), "vc_not_empty after draining full vc");
        end_test("full vc");

        // empty read holds dout and leaves the other VC alone
        prev = dout;
        write_flit(0, make_flit(200));
        read_vc(1);
        expect_read(prev, "dout after empty read");
        check_value(64'(vc_not_empty), 64'(onehot(0)), "vc_not_empty after empty read");
        read_vc(0);
        expect_read(make_flit(200), "read after empty read");
        end_test("empty vc");

        // speculative read alone
        write_flit(0, make_flit(300));
        write_flit(1, make_flit(301));
        wait_not_empty(1);
        ssa_read(1);
        expect_read(make_flit(301), "ssa read");
        write_flit(1, make_flit(302));
        wait_not_empty(1);
        // with both sources at once vc_num_rd wins
        drive(1'b0, 0, '0, 1'b1, 0, onehot(1));
        expect_read(make_flit(300), "rd_en over ssa_rd");
        check_value(64'(vc_not_empty), 64'(onehot(1)), "ssa vc kept its flit");
        ssa_read(1);
        expect_read(make_flit(302), "ssa drain");
        check_value(64'(vc_not_empty), 64'(0), "vc_not_empty after ssa drain");
        end_test("read sources");

        // lfsr traffic checked by the model on every cycle
        for (int c = 0; c < 400; c++) begin
            bits  = take_bits(2);
            r_wr  = |bits[1:0];
            r_wvc = int'(take_bits(`FB_VC_IDX_W)) % `FB_NUM_VC;
            bits  = take_bits(2);
            r_flit.kind    = flit_kind_e'(bits[1:0]);
            r_flit.payload = `FB_PAYLOAD_W'(take_bits(32));
            bits  = take_bits(2);
            mode  = bits[1:0];
            r_rvc = int'(take_bits(`FB_VC_IDX_W)) % `FB_NUM_VC;
            r_svc = int'(take_bits(`FB_VC_IDX_W)) % `FB_NUM_VC;
            // mode bit 0 is rd_en and bit 1 an ssa request
            drive(r_wr, r_wvc, r_flit, mode[0], r_rvc, mode[1] ? onehot(r_svc) : '0);
        end
        @(negedge clk);
        idle_inputs();
        repeat (2) @(negedge clk);
        end_test("random traffic");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+rtl
rtl/flit_buffer_pkg.sv
rtl/vc_ptr_ctrl.sv
rtl/vc_addr_gen.sv
rtl/flit_ram.sv
rtl/flit_buffer.sv
dv/flit_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the flit buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module flit_buffer_tb -o flit_buffer_sim
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/flit_buffer_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    echo "simulation FAILED"
    exit 1
fi

echo "simulation PASSED"
exit 0
